//--- common/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;      // data and immediate words
    typedef logic [4:0]  reg_addr_t;  // register file index
    typedef logic [31:0] inst_t;      // raw instruction word

    // exception vector layout
    localparam int unsigned EXC_W       = 3;
    localparam int unsigned EXC_MRET    = 0;
    localparam int unsigned EXC_ECALL   = 1;
    localparam int unsigned EXC_ILLEGAL = 2;

    typedef logic [EXC_W-1:0] exc_t;

    // RV32I major opcodes that this stage understands
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // full words for the two system instructions that are kept
    localparam inst_t INST_ECALL = 32'h0000_0073;
    localparam inst_t INST_MRET  = 32'h3020_0073;

    // execution unit class seen by the execute stage
    typedef enum logic [2:0] {
        EXE_NOP,
        EXE_LOGIC,
        EXE_ARITH,
        EXE_SHIFT,
        EXE_BRANCH,
        EXE_LOAD_STORE
    } exe_type_e;

    typedef enum logic [5:0] {
        UOP_NOP, UOP_LUI, UOP_AUIPC, UOP_JAL, UOP_JALR,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_XORI, UOP_ORI, UOP_ANDI,
        UOP_SLLI, UOP_SRLI, UOP_SRAI,
        UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
        UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
        UOP_ECALL, UOP_MRET
    } uop_e;

    // true for the micro-ops whose result only exists after memory
    function automatic logic uop_is_load(uop_e uop);
        return uop inside {UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU};
    endfunction

endpackage

//--- decoder/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import id_pkg::*; (
    input  inst_t     inst_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      rs1_re_o,
    output logic      rs2_re_o,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output uop_e      uop_o,
    output exe_type_e alusel_o,
    output word_t     imm_o,
    output exc_t      exc_o
);

    opcode_e   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    logic      illegal;

    word_t imm_i_type;
    word_t imm_s_type;
    word_t imm_b_type;
    word_t imm_u_type;
    word_t imm_j_type;
    word_t imm_shamt;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // source indices go to the register file raw, read enables qualify them
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
    assign imm_shamt  = {27'b0, inst_i[24:20]};  // zero extended

    always_comb begin
        uop_o    = UOP_NOP;
        alusel_o = EXE_NOP;
        imm_o    = '0;
        rs1_re_o = 1'b0;
        rs2_re_o = 1'b0;
        rd_we_o  = 1'b0;
        illegal  = 1'b0;
        exc_o    = '0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                uop_o    = (opcode == OPC_LUI) ? UOP_LUI : UOP_AUIPC;
                alusel_o = EXE_LOGIC;
                imm_o    = imm_u_type;
                rd_we_o  = 1'b1;
            end
            OPC_JAL: begin
                uop_o    = UOP_JAL;
                alusel_o = EXE_BRANCH;
                imm_o    = imm_j_type;
                rd_we_o  = 1'b1;
            end
            OPC_JALR: begin
                uop_o    = UOP_JALR;
                alusel_o = EXE_BRANCH;
                imm_o    = imm_i_type;
                rs1_re_o = 1'b1;
                rd_we_o  = 1'b1;
                illegal  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                alusel_o = EXE_BRANCH;
                imm_o    = imm_b_type;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                case (funct3)
                    3'b000:  uop_o = UOP_BEQ;
                    3'b001:  uop_o = UOP_BNE;
                    3'b100:  uop_o = UOP_BLT;
                    3'b101:  uop_o = UOP_BGE;
                    3'b110:  uop_o = UOP_BLTU;
                    3'b111:  uop_o = UOP_BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                alusel_o = EXE_LOAD_STORE;
                imm_o    = imm_i_type;
                rs1_re_o = 1'b1;
                rd_we_o  = 1'b1;
                case (funct3)
                    3'b000:  uop_o = UOP_LB;
                    3'b001:  uop_o = UOP_LH;
                    3'b010:  uop_o = UOP_LW;
                    3'b100:  uop_o = UOP_LBU;
                    3'b101:  uop_o = UOP_LHU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                alusel_o = EXE_LOAD_STORE;
                imm_o    = imm_s_type;  // address offset, data comes from rs2
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                case (funct3)
                    3'b000:  uop_o = UOP_SB;
                    3'b001:  uop_o = UOP_SH;
                    3'b010:  uop_o = UOP_SW;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                alusel_o = EXE_LOGIC;
                imm_o    = imm_i_type;
                rs1_re_o = 1'b1;
                rd_we_o  = 1'b1;
                case (funct3)
                    3'b000: begin
                        uop_o    = UOP_ADDI;
                        alusel_o = EXE_ARITH;
                    end
                    3'b010: uop_o = UOP_SLTI;
                    3'b011: uop_o = UOP_SLTIU;
                    3'b100: uop_o = UOP_XORI;
                    3'b110: uop_o = UOP_ORI;
                    3'b111: uop_o = UOP_ANDI;
                    default: begin
                        // shift by immediate, shamt[5] must be clear on RV32
                        alusel_o = EXE_SHIFT;
                        imm_o    = imm_shamt;
                        if (funct3 == 3'b001 && funct7 == 7'b0000000) begin
                            uop_o = UOP_SLLI;
                        end else if (funct3 == 3'b101 && funct7 == 7'b0000000) begin
                            uop_o = UOP_SRLI;
                        end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                            uop_o = UOP_SRAI;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            OPC_OP: begin
                alusel_o = EXE_LOGIC;
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                rd_we_o  = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: uop_o = UOP_ADD;
                    {7'b0100000, 3'b000}: uop_o = UOP_SUB;
                    {7'b0000000, 3'b001}: uop_o = UOP_SLL;
                    {7'b0000000, 3'b010}: uop_o = UOP_SLT;
                    {7'b0000000, 3'b011}: uop_o = UOP_SLTU;
                    {7'b0000000, 3'b100}: uop_o = UOP_XOR;
                    {7'b0000000, 3'b101}: uop_o = UOP_SRL;
                    {7'b0100000, 3'b101}: uop_o = UOP_SRA;
                    {7'b0000000, 3'b110}: uop_o = UOP_OR;
                    {7'b0000000, 3'b111}: uop_o = UOP_AND;
                    default:              illegal = 1'b1;
                endcase
                if (uop_o inside {UOP_ADD, UOP_SUB}) begin
                    alusel_o = EXE_ARITH;
                end else if (uop_o inside {UOP_SLL, UOP_SRL, UOP_SRA}) begin
                    alusel_o = EXE_SHIFT;
                end
            end
            OPC_SYSTEM: begin
                // csr access is not supported here, only the two exact words
                if (inst_i == INST_ECALL) begin
                    uop_o            = UOP_ECALL;
                    exc_o[EXC_ECALL] = 1'b1;
                end else if (inst_i == INST_MRET) begin
                    uop_o           = UOP_MRET;
                    exc_o[EXC_MRET] = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase

        // an undefined word leaves nothing behind but the flag
        if (illegal) begin
            uop_o              = UOP_NOP;
            alusel_o           = EXE_NOP;
            imm_o              = '0;
            rs1_re_o           = 1'b0;
            rs2_re_o           = 1'b0;
            rd_we_o            = 1'b0;
            exc_o              = '0;
            exc_o[EXC_ILLEGAL] = 1'b1;
        end
    end

    assign rd_addr_o = rd_we_o ? rd : '0;

    // exceptions are exclusive and never write a register
    always_comb begin
        assert final ($onehot0(exc_o) && (exc_o == '0 || !rd_we_o))
            else $error("decoder raised an exception together with a write or a second flag");
    end

endmodule

//--- rtl/operand_forward.sv
`timescale 1ns/1ns

module operand_forward import id_pkg::*; (
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  word_t     rs1_rdata_i,
    input  word_t     rs2_rdata_i,
    input  uop_e      ex_uop_i,
    input  logic      ex_rd_we_i,
    input  reg_addr_t ex_rd_waddr_i,
    input  word_t     ex_rd_wdata_i,
    input  logic      mem_rd_we_i,
    input  reg_addr_t mem_rd_waddr_i,
    input  word_t     mem_rd_wdata_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output logic      rs1_hazard_o,
    output logic      rs2_hazard_o
);

    logic ex_is_load;

    // youngest writer wins, x0 is hardwired
    function automatic word_t select_operand(
        reg_addr_t addr,
        word_t     rf_data,
        logic      ex_we,
        reg_addr_t ex_addr,
        word_t     ex_data,
        logic      mem_we,
        reg_addr_t mem_addr,
        word_t     mem_data
    );
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (ex_we && ex_addr == addr) begin
            data = ex_data;
        end else if (mem_we && mem_addr == addr) begin
            data = mem_data;
        end else begin
            data = rf_data;
        end
        return data;
    endfunction

    assign ex_is_load = uop_is_load(ex_uop_i);

    assign rs1_data_o = select_operand(rs1_addr_i, rs1_rdata_i,
                                       ex_rd_we_i, ex_rd_waddr_i, ex_rd_wdata_i,
                                       mem_rd_we_i, mem_rd_waddr_i, mem_rd_wdata_i);
    assign rs2_data_o = select_operand(rs2_addr_i, rs2_rdata_i,
                                       ex_rd_we_i, ex_rd_waddr_i, ex_rd_wdata_i,
                                       mem_rd_we_i, mem_rd_waddr_i, mem_rd_wdata_i);

    // load data is not ready until memory, so a match here must wait a cycle
    assign rs1_hazard_o = ex_is_load && (rs1_addr_i != '0) && (ex_rd_waddr_i == rs1_addr_i);
    assign rs2_hazard_o = ex_is_load && (rs2_addr_i != '0) && (ex_rd_waddr_i == rs2_addr_i);

    always_comb begin
        assert final (!(rs1_hazard_o && rs1_addr_i == '0) && !(rs2_hazard_o && rs2_addr_i == '0))
            else $error("load-use hazard flagged on x0");
    end

endmodule

//--- rtl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg import id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      branch_redirect_i,
    input  logic      rs1_re_i,
    input  logic      rs2_re_i,
    input  logic      rd_we_i,
    input  reg_addr_t rd_addr_i,
    input  uop_e      uop_i,
    input  exe_type_e alusel_i,
    input  word_t     imm_i,
    input  exc_t      exc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  logic      rs1_hazard_i,
    input  logic      rs2_hazard_i,
    output logic      stall_req_o,
    output uop_e      uop_o,
    output exe_type_e alusel_o,
    output word_t     imm_o,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output logic      rd_we_o,
    output reg_addr_t rd_waddr_o,
    output exc_t      exception_o
);

    logic  rs1_hazard;
    logic  rs2_hazard;
    logic  bubble;
    word_t rs1_data;
    word_t rs2_data;

    // a hazard only matters for an operand that is actually read
    assign rs1_hazard = rs1_re_i & rs1_hazard_i;
    assign rs2_hazard = rs2_re_i & rs2_hazard_i;

    assign stall_req_o = (rs1_hazard | rs2_hazard) & ~branch_redirect_i;  // redirect flushes anyway
    assign bubble      = stall_req_o | branch_redirect_i;

    assign rs1_data = rs1_re_i ? rs1_data_i : '0;
    assign rs2_data = rs2_re_i ? rs2_data_i : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            uop_o       <= UOP_NOP;
            alusel_o    <= EXE_NOP;
            imm_o       <= '0;
            rs1_data_o  <= '0;
            rs2_data_o  <= '0;
            rd_we_o     <= 1'b0;
            rd_waddr_o  <= '0;
            exception_o <= '0;
        end else begin
            uop_o       <= bubble ? UOP_NOP : uop_i;
            alusel_o    <= bubble ? EXE_NOP : alusel_i;
            imm_o       <= bubble ? '0 : imm_i;
            rs1_data_o  <= bubble ? '0 : rs1_data;
            rs2_data_o  <= bubble ? '0 : rs2_data;
            rd_we_o     <= ~bubble & rd_we_i;
            rd_waddr_o  <= bubble ? '0 : rd_addr_i;
            exception_o <= bubble ? '0 : exc_i;  // flushed exceptions must not fire
        end
    end

    // the stalled instruction is not issued, so execute sees no write
    assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_req_o |=> !rd_we_o && uop_o == UOP_NOP)
        else $error("instruction issued in the cycle after a stall request");

    assert property (@(posedge clk) disable iff (!arst_n_i)
        branch_redirect_i |=> exception_o == '0 && alusel_o == EXE_NOP)
        else $error("redirected instruction reached execute");

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  inst_t     inst_i,
    input  logic      branch_redirect_i,
    input  word_t     rs1_rdata_i,
    input  word_t     rs2_rdata_i,
    input  uop_e      ex_uop_i,
    input  logic      ex_rd_we_i,
    input  reg_addr_t ex_rd_waddr_i,
    input  word_t     ex_rd_wdata_i,
    input  logic      mem_rd_we_i,
    input  reg_addr_t mem_rd_waddr_i,
    input  word_t     mem_rd_wdata_i,
    output reg_addr_t rs1_raddr_o,
    output reg_addr_t rs2_raddr_o,
    output logic      stall_req_o,
    output uop_e      uop_o,
    output exe_type_e alusel_o,
    output word_t     imm_o,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output logic      rd_we_o,
    output reg_addr_t rd_waddr_o,
    output exc_t      exception_o
);

    // decoder results
    logic      dec_rs1_re;
    logic      dec_rs2_re;
    logic      dec_rd_we;
    reg_addr_t dec_rd_addr;
    uop_e      dec_uop;
    exe_type_e dec_alusel;
    word_t     dec_imm;
    exc_t      dec_exc;

    // forwarding results, not yet qualified by the read enables
    word_t fwd_rs1_data;
    word_t fwd_rs2_data;
    logic  fwd_rs1_hazard;
    logic  fwd_rs2_hazard;

    inst_decoder u_decoder (
        .inst_i     (inst_i),
        .rs1_addr_o (rs1_raddr_o),
        .rs2_addr_o (rs2_raddr_o),
        .rs1_re_o   (dec_rs1_re),
        .rs2_re_o   (dec_rs2_re),
        .rd_we_o    (dec_rd_we),
        .rd_addr_o  (dec_rd_addr),
        .uop_o      (dec_uop),
        .alusel_o   (dec_alusel),
        .imm_o      (dec_imm),
        .exc_o      (dec_exc)
    );

    operand_forward u_forward (
        .rs1_addr_i     (rs1_raddr_o),
        .rs2_addr_i     (rs2_raddr_o),
        .rs1_rdata_i    (rs1_rdata_i),
        .rs2_rdata_i    (rs2_rdata_i),
        .ex_uop_i       (ex_uop_i),
        .ex_rd_we_i     (ex_rd_we_i),
        .ex_rd_waddr_i  (ex_rd_waddr_i),
        .ex_rd_wdata_i  (ex_rd_wdata_i),
        .mem_rd_we_i    (mem_rd_we_i),
        .mem_rd_waddr_i (mem_rd_waddr_i),
        .mem_rd_wdata_i (mem_rd_wdata_i),
        .rs1_data_o     (fwd_rs1_data),
        .rs2_data_o     (fwd_rs2_data),
        .rs1_hazard_o   (fwd_rs1_hazard),
        .rs2_hazard_o   (fwd_rs2_hazard)
    );

    id_ex_reg u_id_ex (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .branch_redirect_i (branch_redirect_i),
        .rs1_re_i          (dec_rs1_re),
        .rs2_re_i          (dec_rs2_re),
        .rd_we_i           (dec_rd_we),
        .rd_addr_i         (dec_rd_addr),
        .uop_i             (dec_uop),
        .alusel_i          (dec_alusel),
        .imm_i             (dec_imm),
        .exc_i             (dec_exc),
        .rs1_data_i        (fwd_rs1_data),
        .rs2_data_i        (fwd_rs2_data),
        .rs1_hazard_i      (fwd_rs1_hazard),
        .rs2_hazard_i      (fwd_rs2_hazard),
        .stall_req_o       (stall_req_o),
        .uop_o             (uop_o),
        .alusel_o          (alusel_o),
        .imm_o             (imm_o),
        .rs1_data_o        (rs1_data_o),
        .rs2_data_o        (rs2_data_o),
        .rd_we_o           (rd_we_o),
        .rd_waddr_o        (rd_waddr_o),
        .exception_o       (exception_o)
    );

endmodule

//--- tb/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// instruction formats, each fixing which fields are read, written and used as immediate
typedef enum logic [2:0] {FMT_R, FMT_I, FMT_SH, FMT_S, FMT_B, FMT_U, FMT_J, FMT_SYS} fmt_e;

typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] f3;
    logic       f3_used;
    logic [6:0] f7;
    logic       f7_used;
    exe_type_e  cls;
    fmt_e       fmt;
} enc_t;

// what execute should see for one issued instruction
typedef struct packed {
    uop_e      uop;
    exe_type_e cls;
    word_t     imm;
    word_t     rs1;
    word_t     rs2;
    logic      we;
    reg_addr_t waddr;
    exc_t      exc;
} bundle_t;

// a negative funct value means the field is free
function automatic enc_t make_encoding(opcode_e opc, int f3, int f7, exe_type_e cls, fmt_e fmt);
    enc_t e;
    e.opcode  = opc;
    e.f3_used = (f3 >= 0);
    e.f3      = f3[2:0];
    e.f7_used = (f7 >= 0);
    e.f7      = f7[6:0];
    e.cls     = cls;
    e.fmt     = fmt;
    return e;
endfunction

// RV32I encoding table for every kept micro-op
function automatic enc_t encoding_of(uop_e u);
    enc_t e;
    case (u)
        UOP_LUI:   e = make_encoding(OPC_LUI,    -1, -1, EXE_LOGIC,      FMT_U);
        UOP_AUIPC: e = make_encoding(OPC_AUIPC,  -1, -1, EXE_LOGIC,      FMT_U);
        UOP_JAL:   e = make_encoding(OPC_JAL,    -1, -1, EXE_BRANCH,     FMT_J);
        UOP_JALR:  e = make_encoding(OPC_JALR,    0, -1, EXE_BRANCH,     FMT_I);
        UOP_BEQ:   e = make_encoding(OPC_BRANCH,  0, -1, EXE_BRANCH,     FMT_B);
        UOP_BNE:   e = make_encoding(OPC_BRANCH,  1, -1, EXE_BRANCH,     FMT_B);
        UOP_BLT:   e = make_encoding(OPC_BRANCH,  4, -1, EXE_BRANCH,     FMT_B);
        UOP_BGE:   e = make_encoding(OPC_BRANCH,  5, -1, EXE_BRANCH,     FMT_B);
        UOP_BLTU:  e = make_encoding(OPC_BRANCH,  6, -1, EXE_BRANCH,     FMT_B);
        UOP_BGEU:  e = make_encoding(OPC_BRANCH,  7, -1, EXE_BRANCH,     FMT_B);
        UOP_LB:    e = make_encoding(OPC_LOAD,    0, -1, EXE_LOAD_STORE, FMT_I);
        UOP_LH:    e = make_encoding(OPC_LOAD,    1, -1, EXE_LOAD_STORE, FMT_I);
        UOP_LW:    e = make_encoding(OPC_LOAD,    2, -1, EXE_LOAD_STORE, FMT_I);
        UOP_LBU:   e = make_encoding(OPC_LOAD,    4, -1, EXE_LOAD_STORE, FMT_I);
        UOP_LHU:   e = make_encoding(OPC_LOAD,    5, -1, EXE_LOAD_STORE, FMT_I);
        UOP_SB:    e = make_encoding(OPC_STORE,   0, -1, EXE_LOAD_STORE, FMT_S);
        UOP_SH:    e = make_encoding(OPC_STORE,   1, -1, EXE_LOAD_STORE, FMT_S);
        UOP_SW:    e = make_encoding(OPC_STORE,   2, -1, EXE_LOAD_STORE, FMT_S);
        UOP_ADDI:  e = make_encoding(OPC_OP_IMM,  0, -1, EXE_ARITH,      FMT_I);
        UOP_SLTI:  e = make_encoding(OPC_OP_IMM,  2, -1, EXE_LOGIC,      FMT_I);
        UOP_SLTIU: e = make_encoding(OPC_OP_IMM,  3, -1, EXE_LOGIC,      FMT_I);
        UOP_XORI:  e = make_encoding(OPC_OP_IMM,  4, -1, EXE_LOGIC,      FMT_I);
        UOP_ORI:   e = make_encoding(OPC_OP_IMM,  6, -1, EXE_LOGIC,      FMT_I);
        UOP_ANDI:  e = make_encoding(OPC_OP_IMM,  7, -1, EXE_LOGIC,      FMT_I);
        UOP_SLLI:  e = make_encoding(OPC_OP_IMM,  1,  0, EXE_SHIFT,      FMT_SH);
        UOP_SRLI:  e = make_encoding(OPC_OP_IMM,  5,  0, EXE_SHIFT,      FMT_SH);
        UOP_SRAI:  e = make_encoding(OPC_OP_IMM,  5, 32, EXE_SHIFT,      FMT_SH);
        UOP_ADD:   e = make_encoding(OPC_OP,      0,  0, EXE_ARITH,      FMT_R);
        UOP_SUB:   e = make_encoding(OPC_OP,      0, 32, EXE_ARITH,      FMT_R);
        UOP_SLL:   e = make_encoding(OPC_OP,      1,  0, EXE_SHIFT,      FMT_R);
        UOP_SLT:   e = make_encoding(OPC_OP,      2,  0, EXE_LOGIC,      FMT_R);
        UOP_SLTU:  e = make_encoding(OPC_OP,      3,  0, EXE_LOGIC,      FMT_R);
        UOP_XOR:   e = make_encoding(OPC_OP,      4,  0, EXE_LOGIC,      FMT_R);
        UOP_SRL:   e = make_encoding(OPC_OP,      5,  0, EXE_SHIFT,      FMT_R);
        UOP_SRA:   e = make_encoding(OPC_OP,      5, 32, EXE_SHIFT,      FMT_R);
        UOP_OR:    e = make_encoding(OPC_OP,      6,  0, EXE_LOGIC,      FMT_R);
        UOP_AND:   e = make_encoding(OPC_OP,      7,  0, EXE_LOGIC,      FMT_R);
        UOP_ECALL: e = make_encoding(OPC_SYSTEM, -1, -1, EXE_NOP,        FMT_SYS);
        UOP_MRET:  e = make_encoding(OPC_SYSTEM, -1, -1, EXE_NOP,        FMT_SYS);
        default:   e = '0;
    endcase
    return e;
endfunction

// ecall and mret are only recognized as complete words
function automatic inst_t system_word(uop_e u);
    return (u == UOP_ECALL) ? 32'h0000_0073 : 32'h3020_0073;
endfunction

function automatic bundle_t bubble_bundle();
    return '0;  // nop, no write, no exception
endfunction

// searches the table, anything without a hit is illegal
function automatic void decode_expected(input inst_t inst, output bundle_t b,
                                        output logic re1, output logic re2);
    enc_t e;
    uop_e u;
    logic hit;
    int   k;
    b   = bubble_bundle();
    re1 = 1'b0;
    re2 = 1'b0;
    hit = 1'b0;
    for (k = 1; k <= UOP_MRET; k++) begin
        u = uop_e'(k);
        e = encoding_of(u);
        if (!hit && inst[6:0] == e.opcode
                && (!e.f3_used || inst[14:12] == e.f3)
                && (!e.f7_used || inst[31:25] == e.f7)
                && (e.fmt != FMT_SYS || inst == system_word(u))) begin
            hit   = 1'b1;
            b.uop = u;
            b.cls = e.cls;
            case (e.fmt)
                FMT_R: begin
                    re1  = 1'b1;
                    re2  = 1'b1;
                    b.we = 1'b1;
                end
                FMT_I: begin
                    re1   = 1'b1;
                    b.we  = 1'b1;
                    b.imm = 32'($signed(inst[31:20]));
                end
                FMT_SH: begin
                    re1   = 1'b1;
                    b.we  = 1'b1;
                    b.imm = 32'(inst[24:20]);  // shamt is unsigned
                end
                FMT_S: begin
                    re1   = 1'b1;
                    re2   = 1'b1;
                    b.imm = 32'($signed({inst[31:25], inst[11:7]}));
                end
                FMT_B: begin
                    re1   = 1'b1;
                    re2   = 1'b1;
                    b.imm = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
                end
                FMT_U: begin
                    b.we  = 1'b1;
                    b.imm = {inst[31:12], 12'h000};
                end
                FMT_J: begin
                    b.we  = 1'b1;
                    b.imm = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
                end
                default: b.exc = (u == UOP_ECALL) ? 3'b010 : 3'b001;
            endcase
        end
    end
    if (!hit) begin
        b.exc = 3'b100;
    end
    b.waddr = b.we ? inst[11:7] : '0;
endfunction

// reads the pipeline write-back signals driven by the testbench
function automatic word_t operand_expected(logic re, reg_addr_t a, word_t rf_data);
    if (!re || a == '0) begin
        return '0;
    end
    if (ex_rd_we && ex_rd_waddr == a) begin
        return ex_rd_wdata;  // youngest result first
    end
    if (mem_rd_we && mem_rd_waddr == a) begin
        return mem_rd_wdata;
    end
    return rf_data;
endfunction

function automatic logic hazard_expected(logic re, reg_addr_t a);
    logic ex_load;
    ex_load = ex_uop inside {UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU};
    return re && a != '0 && ex_load && ex_rd_waddr == a;
endfunction

`endif

//--- tb/id_stage_tb.sv
`timescale 1ns/1ns

module id_stage_tb import id_pkg::*; ();

    localparam int N_TESTS      = 2000;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 5;

    logic      clk = 1'b0;
    logic      arst_n;
    inst_t     inst;
    logic      redirect;
    word_t     rs1_rdata;
    word_t     rs2_rdata;
    uop_e      ex_uop;
    logic      ex_rd_we;
    reg_addr_t ex_rd_waddr;
    word_t     ex_rd_wdata;
    logic      mem_rd_we;
    reg_addr_t mem_rd_waddr;
    word_t     mem_rd_wdata;

    reg_addr_t rs1_raddr_o;
    reg_addr_t rs2_raddr_o;
    logic      stall_req_o;
    uop_e      uop_o;
    exe_type_e alusel_o;
    word_t     imm_o;
    word_t     rs1_data_o;
    word_t     rs2_data_o;
    logic      rd_we_o;
    reg_addr_t rd_waddr_o;
    exc_t      exception_o;

    int errors = 0;
    int checks = 0;

`include "id_ref_model.svh"

    bundle_t expect_q[$];  // holds the one instruction in flight

    id_stage dut (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .inst_i            (inst),
        .branch_redirect_i (redirect),
        .rs1_rdata_i       (rs1_rdata),
        .rs2_rdata_i       (rs2_rdata),
        .ex_uop_i          (ex_uop),
        .ex_rd_we_i        (ex_rd_we),
        .ex_rd_waddr_i     (ex_rd_waddr),
        .ex_rd_wdata_i     (ex_rd_wdata),
        .mem_rd_we_i       (mem_rd_we),
        .mem_rd_waddr_i    (mem_rd_waddr),
        .mem_rd_wdata_i    (mem_rd_wdata),
        .rs1_raddr_o       (rs1_raddr_o),
        .rs2_raddr_o       (rs2_raddr_o),
        .stall_req_o       (stall_req_o),
        .uop_o             (uop_o),
        .alusel_o          (alusel_o),
        .imm_o             (imm_o),
        .rs1_data_o        (rs1_data_o),
        .rs2_data_o        (rs2_data_o),
        .rd_we_o           (rd_we_o),
        .rd_waddr_o        (rd_waddr_o),
        .exception_o       (exception_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bundle(input bundle_t e);
        check_value("uop_o", e.uop, uop_o);
        check_value("alusel_o", e.cls, alusel_o);
        check_value("imm_o", e.imm, imm_o);
        check_value("rs1_data_o", e.rs1, rs1_data_o);
        check_value("rs2_data_o", e.rs2, rs2_data_o);
        check_value("rd_we_o", e.we, rd_we_o);
        check_value("rd_waddr_o", e.waddr, rd_waddr_o);
        check_value("exception_o", e.exc, exception_o);
    endtask

    // a kept encoding with random fields, or now and then plain noise
    function automatic inst_t random_inst();
        inst_t word;
        enc_t  e;
        uop_e  u;
        word = $urandom;
        if ($urandom_range(0, 9) == 0) begin
            return word;
        end
        u = uop_e'($urandom_range(1, UOP_MRET));
        if (u inside {UOP_ECALL, UOP_MRET}) begin
            return system_word(u);
        end
        e = encoding_of(u);
        word[6:0] = e.opcode;
        if (e.f3_used) begin
            word[14:12] = e.f3;
        end
        if (e.f7_used) begin
            word[31:25] = e.f7;
        end
        word[11:7]  = $urandom_range(0, 3);  // few registers, many matches
        word[19:15] = $urandom_range(0, 3);
        word[24:20] = $urandom_range(0, 3);
        return word;
    endfunction

    task automatic drive_inputs();
        inst      = random_inst();
        redirect  = ($urandom_range(0, 9) == 0);
        rs1_rdata = $urandom;
        rs2_rdata = $urandom;
        if ($urandom_range(0, 2) == 0) begin
            ex_uop = uop_e'($urandom_range(UOP_LB, UOP_LHU));  // loads made common
        end else begin
            ex_uop = uop_e'($urandom_range(0, UOP_MRET));
        end
        ex_rd_we     = $urandom_range(0, 1);
        ex_rd_waddr  = $urandom_range(0, 3);
        ex_rd_wdata  = $urandom;
        mem_rd_we    = $urandom_range(0, 1);
        mem_rd_waddr = $urandom_range(0, 3);
        mem_rd_wdata = $urandom;
    endtask

    initial begin : watchdog
        #(N_TESTS * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD);
        $display("run timed out, the stimulus did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        bundle_t exp;
        logic    re1;
        logic    re2;
        logic    stall_exp;
        void'($urandom(60));
        arst_n       = 1'b0;
        inst         = '0;
        redirect     = 1'b0;
        rs1_rdata    = '0;
        rs2_rdata    = '0;
        ex_uop       = UOP_NOP;
        ex_rd_we     = 1'b0;
        ex_rd_waddr  = '0;
        ex_rd_wdata  = '0;
        mem_rd_we    = 1'b0;
        mem_rd_waddr = '0;
        mem_rd_wdata = '0;

        // outputs must stay empty whatever the inputs do during reset
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_bundle(bubble_bundle());
            drive_inputs();
        end
        arst_n = 1'b1;
        expect_q.push_back(bubble_bundle());

        repeat (N_TESTS) begin
            check_bundle(expect_q.pop_front());
            drive_inputs();
            decode_expected(inst, exp, re1, re2);
            exp.rs1   = operand_expected(re1, inst[19:15], rs1_rdata);
            exp.rs2   = operand_expected(re2, inst[24:20], rs2_rdata);
            stall_exp = (hazard_expected(re1, inst[19:15]) || hazard_expected(re2, inst[24:20]))
                        && !redirect;
            if (stall_exp || redirect) begin
                exp = bubble_bundle();
            end
            expect_q.push_back(exp);
            @(negedge clk);
            check_value("stall_req_o", stall_exp, stall_req_o);
            check_value("rs1_raddr_o", inst[19:15], rs1_raddr_o);
            check_value("rs2_raddr_o", inst[24:20], rs2_raddr_o);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        check_bundle(expect_q.pop_front());

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- id_stage.f
+incdir+tb
common/id_pkg.sv
decoder/inst_decoder.sv
rtl/operand_forward.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
tb/id_stage_tb.sv
